// ==== common/h80_pkg.sv ====
`default_nettype none

package h80_pkg;

   typedef logic [15:0] word_t;      // register values, addresses, bus data
   typedef logic [15:0] ins_t;
   typedef logic [3:0]  reg_num_t;
   typedef logic [3:0]  flag_num_t;
   typedef logic [2:0]  bus_cmd_t;
   typedef logic [14:0] mem_index_t; // word index, address bits 15:1
   typedef logic [3:0]  alu_op_t;    // top nibble of a three-register op

   typedef enum logic [1:0] {
      st_fetch,
      st_exec,
      st_mem
   } core_state_t;

   localparam int num_regs  = 16;
   localparam int mem_words = 32768;

   // register roles
   localparam reg_num_t reg_pc   = 4'd15;
   localparam reg_num_t reg_sp   = 4'd14;
   localparam reg_num_t reg_flag = 4'd13;

   // bit positions in the flag register
   localparam flag_num_t flag_zero     = 4'd0;
   localparam flag_num_t flag_carry    = 4'd1;
   localparam flag_num_t flag_sign     = 4'd2;
   localparam flag_num_t flag_overflow = 4'd3;
   localparam flag_num_t flag_halt     = 4'd15;

   localparam word_t word_step = 16'd2;  // bytes per word

   localparam bus_cmd_t cmd_read_w  = 3'd0;
   localparam bus_cmd_t cmd_read_b  = 3'd1;
   localparam bus_cmd_t cmd_write_w = 3'd2;
   localparam bus_cmd_t cmd_write_b = 3'd3;

   localparam alu_op_t op_add = 4'd8;
   localparam alu_op_t op_sub = 4'd9;
   localparam alu_op_t op_and = 4'd12;
   localparam alu_op_t op_or  = 4'd13;
   localparam alu_op_t op_xor = 4'd14;
   localparam alu_op_t op_cp  = 4'd15;

   // opcode patterns, operand fields are zero
   localparam ins_t ins_nop      = 16'h0000;
   localparam ins_t ins_halt     = 16'h0001;
   localparam ins_t ins_ret      = 16'h0002;
   localparam ins_t ins_push     = 16'h0100;  // 0100 | r
   localparam ins_t ins_pop      = 16'h0110;  // 0110 | r
   localparam ins_t ins_call     = 16'h01c0;  // 01c0 | r
   localparam ins_t ins_jpn      = 16'h0300;  // 0300 | f << 4 | r
   localparam ins_t ins_jp       = 16'h0340;  // 0340 | f << 4 | r
   localparam ins_t ins_ld_lo    = 16'h1000;  // 1000 | d << 8 | n
   localparam ins_t ins_ld_hi    = 16'h2000;  // 2000 | d << 8 | n
   localparam ins_t ins_mem      = 16'h3000;  // 3000 | cmd << 9 | a << 4 | b
   localparam ins_t ins_mov_to_b = 16'h3c00;  // reg[b] = reg[a]
   localparam ins_t ins_mov_to_a = 16'h3e00;  // reg[a] = reg[b]

endpackage

`default_nettype wire

// ==== common/h80_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface h80_bus_if import h80_pkg::*; ();

   logic     req;      // toggled by the core per request
   logic     done;     // toggled by memory when served
   bus_cmd_t cmd;
   word_t    addr;
   word_t    wr_data;
   word_t    rd_data;  // holds until the next read

   modport core (
      output req, cmd, addr, wr_data,
      input  done, rd_data
   );

   modport mem (
      input  req, cmd, addr, wr_data,
      output done, rd_data
   );

endinterface

`default_nettype wire

// ==== core/h80_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_alu import h80_pkg::*; (
   input  wire alu_op_t op,
   input  wire word_t   a,
   input  wire word_t   b,
   input  wire word_t   flags_in,
   output word_t        result,
   output word_t        flags_out,
   output logic         writes_dest
);

   logic [16:0] a_ext;
   logic [16:0] b_ext;
   logic [16:0] res;
   logic        known;    // mul and div are gone
   logic        is_arith;

   assign a_ext    = {1'b0, a};
   assign b_ext    = {1'b0, b};
   assign known    = (op == op_add) || (op == op_sub) || (op == op_cp) ||
                     (op == op_and) || (op == op_or) || (op == op_xor);
   assign is_arith = (op == op_add) || (op == op_sub) || (op == op_cp);

   always_comb begin
      case (op)
         op_add:        res = a_ext + b_ext;
         op_sub, op_cp: res = a_ext - b_ext;  // bit 16 is the borrow
         op_and:        res = a_ext & b_ext;
         op_or:         res = a_ext | b_ext;
         op_xor:        res = a_ext ^ b_ext;
         default:       res = '0;
      endcase
   end

   always_comb begin
      flags_out = flags_in;  // halt and spare bits pass through
      if (known) begin
         flags_out[flag_sign] = res[15];
         flags_out[flag_zero] = (res[15:0] == 16'h0000);
         if (is_arith) begin
            flags_out[flag_carry] = res[16];
            if (op == op_add)
               flags_out[flag_overflow] = (a[15] == b[15]) && (a[15] != res[15]);
            else
               flags_out[flag_overflow] = (a[15] != b[15]) && (a[15] != res[15]);
         end else begin
            flags_out[flag_carry]    = 1'b0;
            flags_out[flag_overflow] = ~^res[15:0];  // even parity
         end
      end
   end

   assign result      = res[15:0];
   assign writes_dest = known && (op != op_cp);

endmodule

`default_nettype wire

// ==== core/h80_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_regfile import h80_pkg::*; (
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire reg_num_t ra,
   input  wire reg_num_t rb,
   output word_t         a_value,
   output word_t         b_value,
   input  wire logic     we,
   input  wire reg_num_t wnum,
   input  wire word_t    wdata,
   input  wire logic     flag_we,
   input  wire word_t    flag_value,
   input  wire logic     pc_we,
   input  wire word_t    pc_next,
   input  wire reg_num_t dbg_reg,
   output word_t         dbg_value,
   output word_t         pc_value,
   output word_t         sp_value,
   output word_t         flag_value_out
);

   word_t regs [num_regs];

   assign a_value        = regs[ra];
   assign b_value        = regs[rb];
   assign dbg_value      = regs[dbg_reg];
   assign pc_value       = regs[reg_pc];
   assign sp_value       = regs[reg_sp];
   assign flag_value_out = regs[reg_flag];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs[reg_pc]   <= '0;
         regs[reg_sp]   <= '0;
         regs[reg_flag] <= '0;
      end else begin
         if (pc_we)
            regs[reg_pc] <= pc_next;
         if (flag_we)
            regs[reg_flag] <= flag_value;
         if (we)
            regs[wnum] <= wdata;  // last, so an explicit write wins
      end
   end

endmodule

`default_nettype wire

// ==== core/h80_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_core import h80_pkg::*; (
   input  wire logic     clk,
   input  wire logic     reset,
   input  wire reg_num_t dbg_reg,
   h80_bus_if.core       bus,
   output word_t         dbg_value,
   output word_t         pc,
   output logic          halted
);

   core_state_t state;
   reg_num_t    mem_dest;    // destination of a pending read
   logic        pending;
   logic        is_read;
   ins_t        ins;
   reg_num_t    ra;
   reg_num_t    rb;
   word_t       a_value;
   word_t       b_value;
   word_t       pc_value;
   word_t       sp_value;
   word_t       flags;
   logic        we;
   reg_num_t    wnum;
   word_t       wdata;
   logic        flag_we;
   word_t       flag_next;
   logic        pc_we;
   word_t       pc_next;
   word_t       alu_result;
   word_t       alu_flags;
   logic        alu_writes;
   logic        mem_go;
   bus_cmd_t    mem_cmd;
   word_t       mem_addr;
   word_t       mem_wdata;
   reg_num_t    mem_rd_reg;
   flag_num_t   jump_flag;

   assign pending   = bus.req != bus.done;
   assign is_read   = (bus.cmd == cmd_read_w) || (bus.cmd == cmd_read_b);
   assign ins       = bus.rd_data;  // fetched word stays until the next read
   assign jump_flag = flag_num_t'(ins[5:4]);
   assign rb        = ins[3:0];
   // byte immediates read their own destination, st_mem reads the load target
   assign ra = (state == st_mem) ? mem_dest :
               ((ins[15:12] == ins_ld_lo[15:12]) || (ins[15:12] == ins_ld_hi[15:12])) ?
               ins[11:8] : ins[7:4];
   assign pc     = pc_value;
   assign halted = flags[flag_halt];

   h80_regfile u_regfile (
      .clk, .reset, .ra, .rb, .a_value, .b_value,
      .we, .wnum, .wdata,
      .flag_we, .flag_value(flag_next),
      .pc_we, .pc_next,
      .dbg_reg, .dbg_value,
      .pc_value, .sp_value, .flag_value_out(flags)
   );

   h80_alu u_alu (
      .op(alu_op_t'(ins[15:12])), .a(a_value), .b(b_value), .flags_in(flags),
      .result(alu_result), .flags_out(alu_flags), .writes_dest(alu_writes)
   );

   always_comb begin
      we         = 1'b0;
      wnum       = ins[11:8];
      wdata      = alu_result;
      flag_we    = 1'b0;
      flag_next  = alu_flags;
      pc_we      = 1'b0;
      pc_next    = pc_value + word_step;
      mem_go     = 1'b0;
      mem_cmd    = cmd_read_w;
      mem_addr   = sp_value;
      mem_wdata  = a_value;
      mem_rd_reg = ins[3:0];
      if (state == st_exec && !pending && !halted) begin
         pc_we = 1'b1;
         if (ins == ins_halt) begin
            flag_we   = 1'b1;
            flag_next = flags | (word_t'(1) << flag_halt);
         end else if (ins == ins_ret) begin
            mem_go     = 1'b1;           // pop return address into pc
            mem_rd_reg = reg_pc;
            we         = 1'b1;
            wnum       = reg_sp;
            wdata      = sp_value + word_step;
         end else if (ins[15:4] == ins_push[15:4] || ins[15:4] == ins_call[15:4]) begin
            mem_go    = 1'b1;            // pre-decrement sp
            mem_cmd   = cmd_write_w;
            mem_addr  = sp_value - word_step;
            mem_wdata = (ins[15:4] == ins_call[15:4]) ? pc_value + word_step : b_value;
            we        = 1'b1;
            wnum      = reg_sp;
            wdata     = sp_value - word_step;
            if (ins[15:4] == ins_call[15:4])
               pc_next = b_value;
         end else if (ins[15:4] == ins_pop[15:4]) begin
            mem_go = 1'b1;               // post-increment sp
            we     = 1'b1;
            wnum   = reg_sp;
            wdata  = sp_value + word_step;
         end else if (ins[15:6] == ins_jp[15:6] || ins[15:6] == ins_jpn[15:6]) begin
            if (flags[jump_flag] == ins[6])  // bit 6 set for jp, clear for jpn
               pc_next = b_value;
         end else if (ins[15:12] == ins_ld_lo[15:12]) begin
            we    = 1'b1;
            wdata = {a_value[15:8], ins[7:0]};
         end else if (ins[15:12] == ins_ld_hi[15:12]) begin
            we    = 1'b1;
            wdata = {ins[7:0], a_value[7:0]};
         end else if (ins[15:11] == ins_mem[15:11] && !ins[8]) begin
            mem_go     = 1'b1;           // a: data reg, b: address reg
            mem_cmd    = bus_cmd_t'(ins[11:9]);
            mem_addr   = b_value;
            mem_rd_reg = ins[7:4];
         end else if (ins[15:9] == ins_mov_to_b[15:9] && !ins[8]) begin
            we    = 1'b1;
            wnum  = ins[3:0];
            wdata = a_value;
         end else if (ins[15:9] == ins_mov_to_a[15:9] && !ins[8]) begin
            we    = 1'b1;
            wnum  = ins[7:4];
            wdata = b_value;
         end else if (ins[15]) begin
            we      = alu_writes;
            flag_we = 1'b1;
         end
      end else if (state == st_mem && !pending && is_read) begin
         we    = 1'b1;
         wnum  = mem_dest;
         wdata = (bus.cmd == cmd_read_b) ? {a_value[15:8], bus.rd_data[7:0]} : bus.rd_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_fetch;
         bus.req <= 1'b0;
      end else if (!halted && !pending) begin
         case (state)
            st_fetch: begin
               bus.req  <= ~bus.req;
               bus.cmd  <= cmd_read_w;
               bus.addr <= pc_value;
               state    <= st_exec;
            end
            st_exec: begin
               if (mem_go) begin
                  bus.req     <= ~bus.req;
                  bus.cmd     <= mem_cmd;
                  bus.addr    <= mem_addr;
                  bus.wr_data <= mem_wdata;
                  mem_dest    <= mem_rd_reg;
                  state       <= st_mem;
               end else begin
                  state <= st_fetch;
               end
            end
            default: state <= st_fetch;  // st_mem, read data written above
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/h80_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_mem import h80_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       prog_we,
   input  wire mem_index_t prog_index,
   input  wire word_t      prog_data,
   h80_bus_if.mem          bus
);

   word_t      mem [mem_words];
   mem_index_t index;
   logic       serve;

   assign index = bus.addr[15:1];
   assign serve = !reset && (bus.req != bus.done);

   // writes, program load first
   always_ff @(posedge clk) begin
      if (prog_we) begin
         mem[prog_index] <= prog_data;
      end else if (serve) begin
         case (bus.cmd)
            cmd_write_w: mem[index] <= bus.wr_data;
            cmd_write_b: begin
               if (bus.addr[0])
                  mem[index][15:8] <= bus.wr_data[7:0];  // odd byte is the high lane
               else
                  mem[index][7:0] <= bus.wr_data[7:0];
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (serve) begin
         case (bus.cmd)
            cmd_read_w: bus.rd_data <= mem[index];
            cmd_read_b: begin
               if (bus.addr[0])
                  bus.rd_data <= {8'h00, mem[index][15:8]};
               else
                  bus.rd_data <= {8'h00, mem[index][7:0]};
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         bus.done <= 1'b0;
      else if (serve)
         bus.done <= ~bus.done;  // match req, request served
   end

endmodule

`default_nettype wire

// ==== src/h80_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_top import h80_pkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire logic       prog_we,
   input  wire mem_index_t prog_index,
   input  wire word_t      prog_data,
   input  wire reg_num_t   dbg_reg,
   output word_t           dbg_value,
   output word_t           pc,
   output logic            halted
);

   h80_bus_if bus ();

   h80_core u_core (
      .clk,
      .reset,
      .dbg_reg,
      .bus(bus.core),
      .dbg_value,
      .pc,
      .halted
   );

   h80_mem u_mem (
      .clk,
      .reset,
      .prog_we,
      .prog_index,
      .prog_data,
      .bus(bus.mem)
   );

endmodule

`default_nettype wire

// ==== verif/h80_bus_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_bus_chk import h80_pkg::*; (
   input wire logic     clk,
   input wire logic     reset,
   input wire logic     req,
   input wire logic     done,
   input wire bus_cmd_t cmd,
   input wire word_t    addr,
   input wire logic     halted
);

   // one request at a time
   req_hold: assert property (@(posedge clk) disable iff (reset)
      (req != done) |=> $stable(req))
      else $error("bus req toggled while a request was pending");

   cmd_hold: assert property (@(posedge clk) disable iff (reset)
      (req != done) |=> ($stable(cmd) && $stable(addr)))
      else $error("bus cmd or addr changed while a request was pending");

   halt_hold: assert property (@(posedge clk) disable iff (reset)
      halted |=> halted)
      else $error("halted fell without a reset");

endmodule

bind h80_core h80_bus_chk u_bus_chk (
   .clk(clk),
   .reset(reset),
   .req(bus.req),
   .done(bus.done),
   .cmd(bus.cmd),
   .addr(bus.addr),
   .halted(halted)
);

`default_nettype wire

// ==== verif/h80_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module h80_tb import h80_pkg::*; ();

   logic       clk;
   logic       reset;
   logic       prog_we;
   mem_index_t prog_index;
   word_t      prog_data;
   reg_num_t   dbg_reg;
   word_t      dbg_value;
   word_t      pc;
   logic       halted;

   word_t   prog [$];  // program being assembled
   int      test_errors;
   int      tests_run;
   int      tests_failed;
   alu_op_t ops [6]      = '{op_add, op_sub, op_and, op_or, op_xor, op_cp};
   string   op_names [6] = '{"add", "sub", "and", "or", "xor", "cp"};

   h80_top uut (
      .clk, .reset, .prog_we, .prog_index, .prog_data,
      .dbg_reg, .dbg_value, .pc, .halted
   );

   always #5 clk = ~clk;

   // expected {flags, result} of a three-register op
   function automatic logic [31:0] ref_alu(alu_op_t op, word_t a, word_t b, word_t flags);
      logic [16:0] wide;
      word_t       f;
      f    = flags;
      wide = '0;
      case (op)
         op_add:        wide = {1'b0, a} + {1'b0, b};
         op_sub, op_cp: wide = {1'b0, a} - {1'b0, b};
         op_and:        wide = {1'b0, a & b};
         op_or:         wide = {1'b0, a | b};
         op_xor:        wide = {1'b0, a ^ b};
         default:       wide = '0;
      endcase
      f[flag_sign] = wide[15];
      f[flag_zero] = (wide[15:0] == 16'h0000);
      if (op == op_add) begin
         f[flag_carry]    = wide[16];
         f[flag_overflow] = (a[15] == b[15]) && (wide[15] != a[15]);
      end else if (op == op_sub || op == op_cp) begin
         f[flag_carry]    = (a < b);  // borrow
         f[flag_overflow] = (a[15] != b[15]) && (wide[15] != a[15]);
      end else begin
         f[flag_carry]    = 1'b0;
         f[flag_overflow] = ~^wide[15:0];  // even parity
      end
      return {f, wide[15:0]};
   endfunction

   function automatic ins_t alu_ins(alu_op_t op, reg_num_t d, reg_num_t a, reg_num_t b);
      return {op, d, a, b};
   endfunction

   function automatic ins_t mem_ins(bus_cmd_t cmd, reg_num_t a, reg_num_t b);
      return ins_mem | {4'h0, cmd, 1'b0, a, b};  // a holds the data and b the address
   endfunction

   function automatic ins_t jump_ins(logic on_set, logic [1:0] f, reg_num_t r);
      return (on_set ? ins_jp : ins_jpn) | {10'h000, f, r};
   endfunction

   task automatic load_const(input reg_num_t d, input word_t v);
      prog.push_back(ins_ld_lo | {4'h0, d, v[7:0]});
      prog.push_back(ins_ld_hi | {4'h0, d, v[15:8]});
   endtask

   // load during reset and run until halt
   task automatic run_program();
      int cycles;
      for (int i = 0; i < 16 || i < prog.size(); i++) begin
         @(negedge clk);
         reset      = 1'b1;
         prog_we    = (i < prog.size());
         prog_index = mem_index_t'(i);
         prog_data  = (i < prog.size()) ? prog[i] : ins_nop;
      end
      @(negedge clk);
      prog_we = 1'b0;
      reset   = 1'b0;
      cycles  = 0;
      while (!halted && cycles < 1000) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("Error at time %0t: core did not halt within 1000 cycles", $time);
         test_errors++;
      end
      prog.delete();
   endtask

   task automatic read_reg(input reg_num_t r, output word_t v);
      @(negedge clk);
      dbg_reg = r;
      @(posedge clk);
      v = dbg_value;  // registers hold still while halted
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic check_reg(input reg_num_t r, input word_t exp);
      word_t v;
      read_reg(r, v);
      check_value($sformatf("r%0d", r), v, exp);
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   initial begin
      word_t       a;
      word_t       b;
      word_t       old;
      word_t       v;
      logic [31:0] exp_word;
      logic [7:0]  v1;
      logic [7:0]  v2;
      logic        taken;
      void'($urandom(32'h5d30));
      clk          = 1'b0;
      reset        = 1'b1;
      prog_we      = 1'b0;
      prog_index   = '0;
      prog_data    = '0;
      dbg_reg      = '0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;

      prog.push_back(ins_halt);
      run_program();
      check_value("pc", pc, 16'h0002);
      check_reg(reg_sp, 16'h0000);
      read_reg(reg_flag, v);
      check_value("flags", v & 16'h7fff, 16'h0000);  // halt bit aside
      finish_test("halt after reset");

      for (int n = 0; n < 2; n++) begin
         foreach (ops[k]) begin
            a   = word_t'($urandom);
            b   = word_t'($urandom);
            old = word_t'($urandom);
            load_const(4'd1, a);
            load_const(4'd2, b);
            load_const(4'd3, old);
            prog.push_back(alu_ins(ops[k], 4'd3, 4'd1, 4'd2));
            prog.push_back(ins_halt);
            run_program();
            exp_word = ref_alu(ops[k], a, b, 16'h0000);
            check_reg(4'd3, (ops[k] == op_cp) ? old : exp_word[15:0]);
            check_reg(reg_flag, exp_word[31:16] | 16'h8000);
            finish_test($sformatf("alu %s round %0d", op_names[k], n));
         end
      end

      a   = 16'h4000 | (word_t'($urandom) & 16'h0ffe);  // even address clear of code
      b   = word_t'($urandom);
      old = word_t'($urandom);
      v   = word_t'($urandom);
      load_const(4'd1, a);
      load_const(4'd4, a | 16'h0001);
      load_const(4'd2, b);
      load_const(4'd3, old);
      load_const(4'd6, v);
      load_const(4'd7, ~v);
      prog.push_back(mem_ins(cmd_write_w, 4'd2, 4'd1));
      prog.push_back(mem_ins(cmd_write_b, 4'd3, 4'd4));
      prog.push_back(mem_ins(cmd_read_w, 4'd5, 4'd1));
      prog.push_back(mem_ins(cmd_read_b, 4'd6, 4'd4));
      prog.push_back(mem_ins(cmd_read_b, 4'd7, 4'd1));
      prog.push_back(ins_halt);
      run_program();
      check_reg(4'd5, {old[7:0], b[7:0]});  // odd byte is the high lane
      check_reg(4'd6, {v[15:8], old[7:0]});
      check_reg(4'd7, {~v[15:8], b[7:0]});
      finish_test("word and byte memory access");

      for (int jp = 0; jp < 2; jp++) begin
         for (int eq = 0; eq < 2; eq++) begin
            v1 = 8'($urandom);
            v2 = (eq == 1) ? v1 : v1 ^ 8'h5a;
            taken = (jp == 1) ? (eq == 1) : (eq == 0);
            load_const(4'd1, {8'h00, v1});
            load_const(4'd2, {8'h00, v2});
            load_const(4'd3, 16'd24);  // word 12
            load_const(4'd4, 16'h0000);
            prog.push_back(alu_ins(op_cp, 4'd0, 4'd1, 4'd2));
            prog.push_back(jump_ins(jp == 1, flag_zero[1:0], 4'd3));
            prog.push_back(ins_ld_lo | {4'h0, 4'd4, 8'h55});
            prog.push_back(ins_halt);
            prog.push_back(ins_ld_lo | {4'h0, 4'd4, 8'haa});
            prog.push_back(ins_halt);
            run_program();
            check_reg(4'd4, taken ? 16'h00aa : 16'h0055);
            check_value("pc", pc, taken ? 16'd28 : 16'd24);
            finish_test($sformatf("%s zero, equal %0d", (jp == 1) ? "jp" : "jpn", eq));
         end
      end

      a = word_t'($urandom);
      load_const(4'd1, a);
      load_const(4'd2, 16'd16);  // routine at word 8
      prog.push_back(ins_push | {12'h000, 4'd1});
      prog.push_back(ins_call | {12'h000, 4'd2});
      prog.push_back(ins_pop | {12'h000, 4'd6});
      prog.push_back(ins_halt);
      prog.push_back(ins_pop | {12'h000, 4'd5});  // return address
      prog.push_back(ins_push | {12'h000, 4'd5});
      prog.push_back(ins_ret);
      run_program();
      check_reg(4'd6, a);
      check_reg(4'd5, 16'd12);
      check_reg(reg_sp, 16'h0000);
      check_value("pc", pc, 16'd16);
      finish_test("push, call, pop and ret");

      $display("tests run: %0d, failed: %0d", tests_run, tests_failed);
      if (tests_failed == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
common/h80_pkg.sv
common/h80_bus_if.sv
core/h80_alu.sv
core/h80_regfile.sv
core/h80_core.sv
src/h80_mem.sv
src/h80_top.sv
verif/h80_bus_chk.sv
verif/h80_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= h80_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
